/* multicore_energy.f */
rtl/stream_pkg.sv
rtl/block_dispatcher.sv
rtl/energy_core.sv
rtl/result_collector.sv
rtl/multicore_energy.sv
tb/multicore_energy_assert.sv
tb/multicore_energy_tb.sv

/* tb/multicore_energy_tb.sv */
`timescale 1ns/1ps

module multicore_energy_tb;

	localparam int STREAM_BLOCKS  = 40;
	localparam int STALL_BLOCKS   = 24;
	localparam int EARLY_BLOCKS   = 3;
	localparam int RESTART_BLOCKS = 8;
	localparam int TOTAL_BLOCKS   = 1 + STREAM_BLOCKS + STALL_BLOCKS + EARLY_BLOCKS
		+ RESTART_BLOCKS;
	localparam real CLK_PERIOD_NS = 100.0;
	localparam real WATCHDOG_NS   = (TOTAL_BLOCKS * 100 + 1000) * CLK_PERIOD_NS;

	logic                 clk;
	logic                 arst_n;
	stream_pkg::sample_t  sample_in;
	logic                 sample_take;
	stream_pkg::acc_t     result;
	logic                 result_valid;
	stream_pkg::core_id_t result_core;

	logic [31:0]         lfsr_state;
	stream_pkg::sample_t feed_q [$];
	bit                  presented_real;

	// Reference model state, built from the samples that the DUT consumes.
	longint              part_sum;
	int                  part_len;
	bit                  part_real;
	int                  block_count;
	stream_pkg::acc_t    exp_value_q [$];
	int                  exp_core_q [$];
	bit                  exp_real_q [$];

	int                  taken_real;
	int                  stall_cycles;
	int                  real_results;
	int                  results_seen;
	stream_pkg::acc_t    first_value;
	int                  first_core;
	int                  error_count;
	int                  tests_run;

	multicore_energy dut_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.sample_in    (sample_in),
		.sample_take  (sample_take),
		.result       (result),
		.result_valid (result_valid),
		.result_core  (result_core)
	);

	always #50 clk = ~clk;

	// Taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic stream_pkg::sample_t random_sample();
		stream_pkg::sample_t s;
		s = '0;
		for (int i = 0; i < stream_pkg::SAMPLE_W; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			s = {s[stream_pkg::SAMPLE_W-2:0], lfsr_state[0]};
		end
		return s;
	endfunction

	function automatic longint square(input stream_pkg::sample_t s);
		longint v;
		v = s;
		return v * v;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic model_sample(input stream_pkg::sample_t s, input bit is_real);
		part_sum += square(s);
		part_real |= is_real;
		part_len++;
		if (part_len == stream_pkg::BLOCK_LEN) begin
			exp_value_q.push_back(stream_pkg::acc_t'(part_sum));
			exp_core_q.push_back(block_count % stream_pkg::NUM_CORES);
			exp_real_q.push_back(part_real);
			block_count++;
			part_sum  = 0;
			part_len  = 0;
			part_real = 1'b0;
		end
	endtask

	// Zeros are presented once the queue runs dry, since the DUT keeps pulling.
	always @(posedge clk) begin
		if (!arst_n) begin
			part_sum    = 0;
			part_len    = 0;
			part_real   = 1'b0;
			block_count = 0;
			exp_value_q.delete();
			exp_core_q.delete();
			exp_real_q.delete();
		end else if (sample_take) begin
			model_sample(sample_in, presented_real);
			if (presented_real) begin
				feed_q.delete(0);
				taken_real++;
			end
		end else if (presented_real) begin
			stall_cycles++;
		end
		presented_real = (feed_q.size() > 0);
		if (presented_real) begin
			sample_in <= feed_q[0];
		end else begin
			sample_in <= '0;
		end
	end

	always @(posedge clk) begin
		if (arst_n && result_valid) begin
			results_seen++;
			if (exp_value_q.size() == 0) begin
				$display("Result at %0t from core %0d has no block behind it", $time,
					result_core);
				error_count++;
			end else begin
				if (result !== exp_value_q[0]) begin
					report_mismatch("result", exp_value_q[0], result);
				end
				if (result_core !== exp_core_q[0]) begin
					report_mismatch("result_core", exp_core_q[0], result_core);
				end
				if (exp_real_q[0]) begin
					if (real_results == 0) begin
						first_value = result;
						first_core  = result_core;
					end
					real_results++;
				end
				exp_value_q.delete(0);
				exp_core_q.delete(0);
				exp_real_q.delete(0);
			end
		end
	end

	task automatic assert_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		@(negedge clk);
		feed_q.delete();
		taken_real   = 0;
		stall_cycles = 0;
		real_results = 0;
	endtask

	task automatic release_reset();
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	task automatic queue_random_blocks(input int blocks);
		for (int i = 0; i < blocks * stream_pkg::BLOCK_LEN; i++) begin
			feed_q.push_back(random_sample());
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
	endtask

	task automatic test_reset_state();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			if (result_valid !== 1'b0) begin
				report_mismatch("result_valid", 0, result_valid);
			end
			if (sample_take !== 1'b1) begin
				report_mismatch("sample_take", 1, sample_take);
			end
		end
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		if (result_valid !== 1'b0) begin
			report_mismatch("result_valid", 0, result_valid);
		end
		if (sample_take !== 1'b1) begin
			report_mismatch("sample_take", 1, sample_take);
		end
		finish_test("reset state", errors_before);
	endtask

	task automatic test_known_block();
		int errors_before;
		errors_before = error_count;
		assert_reset();
		feed_q.push_back(stream_pkg::sample_t'(3));
		feed_q.push_back(stream_pkg::sample_t'(-4));
		feed_q.push_back(stream_pkg::sample_t'(0));
		feed_q.push_back(stream_pkg::sample_t'(-32768));
		release_reset();
		wait (real_results >= 1);
		if (first_core != 0) begin
			report_mismatch("result_core", 0, first_core);
		end
		if (first_value !== 36'd1073741849) begin
			report_mismatch("result", 36'd1073741849, first_value);
		end
		finish_test("known block", errors_before);
	endtask

	task automatic test_stream();
		int errors_before;
		errors_before = error_count;
		assert_reset();
		queue_random_blocks(STREAM_BLOCKS);
		release_reset();
		wait (real_results >= STREAM_BLOCKS);
		if (taken_real != STREAM_BLOCKS * stream_pkg::BLOCK_LEN) begin
			$display("Stream consumed %0d samples instead of %0d", taken_real,
				STREAM_BLOCKS * stream_pkg::BLOCK_LEN);
			error_count++;
		end
		finish_test("stream", errors_before);
	endtask

	task automatic test_stalls();
		int errors_before;
		errors_before = error_count;
		assert_reset();
		queue_random_blocks(STALL_BLOCKS);
		release_reset();
		wait (real_results >= STALL_BLOCKS);
		@(negedge clk);
		if (stall_cycles == 0) begin
			$display("sample_take never went low while samples were waiting");
			error_count++;
		end
		if (real_results != STALL_BLOCKS || feed_q.size() != 0) begin
			$display("Got %0d results with %0d samples left over", real_results,
				feed_q.size());
			error_count++;
		end
		if (taken_real != stream_pkg::BLOCK_LEN * real_results) begin
			$display("%0d samples taken for %0d results", taken_real, real_results);
			error_count++;
		end
		finish_test("stalls", errors_before);
	endtask

	task automatic test_restart();
		int errors_before;
		longint first_energy;
		stream_pkg::sample_t s;
		errors_before = error_count;
		assert_reset();
		queue_random_blocks(EARLY_BLOCKS);
		release_reset();
		// Two full blocks and half of the third are in by now.
		wait (taken_real >= 2 * stream_pkg::BLOCK_LEN + 2);
		assert_reset();
		first_energy = 0;
		for (int i = 0; i < RESTART_BLOCKS * stream_pkg::BLOCK_LEN; i++) begin
			s = random_sample();
			if (i < stream_pkg::BLOCK_LEN) begin
				first_energy += square(s);
			end
			feed_q.push_back(s);
		end
		release_reset();
		wait (real_results >= RESTART_BLOCKS);
		if (first_core != 0) begin
			report_mismatch("result_core", 0, first_core);
		end
		if (first_value !== stream_pkg::acc_t'(first_energy)) begin
			report_mismatch("result", first_energy, first_value);
		end
		finish_test("mid-run reset", errors_before);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0t with results still outstanding", $time);
		$display("Errors found");
		$finish;
	end

	initial begin
		clk            = 1'b0;
		arst_n         = 1'b0;
		sample_in      = '0;
		lfsr_state     = 32'hee2c9119;
		presented_real = 1'b0;
		taken_real     = 0;
		stall_cycles   = 0;
		real_results   = 0;
		results_seen   = 0;
		error_count    = 0;
		tests_run      = 0;
		test_reset_state();
		test_known_block();
		test_stream();
		test_stalls();
		test_restart();
		repeat (4) @(posedge clk);
		$display("Summary: %0d tests, %0d results checked, %0d errors, %0d assertion failures",
			tests_run, results_seen, error_count, dut_i.assert_i.fail_count);
		if (error_count == 0 && dut_i.assert_i.fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* tb/multicore_energy_assert.sv */
`timescale 1ns/1ps

module multicore_energy_assert (
	input logic                             clk,
	input logic                             arst_n,
	input logic                             sample_take,
	input logic [stream_pkg::NUM_CORES-1:0] core_load,
	input stream_pkg::acc_t                 result,
	input logic                             result_valid,
	input stream_pkg::core_id_t             result_core
);

	int                   fail_load = 0;
	int                   fail_take = 0;
	int                   fail_pulse = 0;
	int                   fail_order = 0;
	int                   fail_known = 0;
	int                   fail_count;
	stream_pkg::core_id_t last_core;
	logic                 have_last;
	stream_pkg::core_id_t next_core;

	assign fail_count = fail_load + fail_take + fail_pulse + fail_order + fail_known;

	// The first result after reset comes from core 0.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_core <= '0;
			have_last <= 1'b0;
		end else if (result_valid) begin
			last_core <= result_core;
			have_last <= 1'b1;
		end
	end

	assign next_core = have_last ?
		stream_pkg::core_id_t'((int'(last_core) + 1) % stream_pkg::NUM_CORES) : '0;

	load_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(core_load))
		else begin $error("more than one core_load bit is set"); fail_load++; end

	take_matches_load: assert property (@(posedge clk) disable iff (!arst_n)
		sample_take == (|core_load))
		else begin $error("sample_take differs from the OR of core_load"); fail_take++; end

	valid_is_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |=> !result_valid)
		else begin $error("result_valid stayed high for two cycles"); fail_pulse++; end

	core_in_order: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |-> result_core == next_core)
		else begin $error("result_core is out of round-robin order"); fail_order++; end

	outputs_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({sample_take, result_valid}) &&
		(!result_valid || !$isunknown({result, result_core})))
		else begin $error("DUT output is unknown after reset"); fail_known++; end

endmodule

bind multicore_energy multicore_energy_assert assert_i (.*);

/* rtl/multicore_energy.sv */
`timescale 1ns/1ps

module multicore_energy (
	input  logic                 clk,
	input  logic                 arst_n,
	input  stream_pkg::sample_t  sample_in,
	output logic                 sample_take,
	output stream_pkg::acc_t     result,
	output logic                 result_valid,
	output stream_pkg::core_id_t result_core
);

	stream_pkg::sample_t                 core_sample;
	logic                                core_last;
	logic [stream_pkg::NUM_CORES-1:0]    core_load;
	logic [stream_pkg::NUM_CORES-1:0]    core_ready;
	logic [stream_pkg::NUM_CORES-1:0]    core_done;
	logic [stream_pkg::NUM_CORES-1:0]    core_collect;
	stream_pkg::acc_t                    core_result [stream_pkg::NUM_CORES];

	block_dispatcher dispatcher_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.sample_in   (sample_in),
		.core_ready  (core_ready),
		.sample_take (sample_take),
		.core_sample (core_sample),
		.core_last   (core_last),
		.core_load   (core_load)
	);

	// Sample and last are shared; each core only acts on its own load bit.
	for (genvar i = 0; i < stream_pkg::NUM_CORES; i++) begin : g_core
		energy_core core_i (
			.clk     (clk),
			.arst_n  (arst_n),
			.sample  (core_sample),
			.load    (core_load[i]),
			.last    (core_last),
			.collect (core_collect[i]),
			.ready   (core_ready[i]),
			.done    (core_done[i]),
			.result  (core_result[i])
		);
	end

	result_collector collector_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.core_done    (core_done),
		.core_result  (core_result),
		.core_collect (core_collect),
		.result       (result),
		.result_valid (result_valid),
		.result_core  (result_core)
	);

endmodule

/* rtl/result_collector.sv */
`timescale 1ns/1ps

module result_collector (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic [stream_pkg::NUM_CORES-1:0]    core_done,
	input  stream_pkg::acc_t                    core_result [stream_pkg::NUM_CORES],
	output logic [stream_pkg::NUM_CORES-1:0]    core_collect,
	output stream_pkg::acc_t                    result,
	output logic                                result_valid,
	output stream_pkg::core_id_t                result_core
);

	stream_pkg::core_id_t ptr;
	logic                 take;

	assign take = core_done[ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr          <= '0;
			core_collect <= '0;
			result       <= '0;
			result_valid <= 1'b0;
			result_core  <= '0;
		end else begin
			core_collect <= '0;
			result_valid <= 1'b0;
			if (take) begin
				result            <= core_result[ptr];
				result_core       <= ptr;
				result_valid      <= 1'b1;
				core_collect[ptr] <= 1'b1;
				// Same order as the dispatcher, which keeps the results in block order.
				if (ptr == stream_pkg::core_id_t'(stream_pkg::NUM_CORES - 1)) begin
					ptr <= '0;
				end else begin
					ptr <= ptr + 1'b1;
				end
			end
		end
	end

endmodule

/* rtl/energy_core.sv */
`timescale 1ns/1ps

module energy_core (
	input  logic                clk,
	input  logic                arst_n,
	input  stream_pkg::sample_t sample,
	input  logic                load,
	input  logic                last,
	input  logic                collect,
	output logic                ready,
	output logic                done,
	output stream_pkg::acc_t    result
);

	typedef enum logic [1:0] {
		st_idle,
		st_fill,
		st_square,
		st_hold
	} state_t;

	state_t               state;
	stream_pkg::sample_t  sample_buf [stream_pkg::BLOCK_LEN];
	stream_pkg::slot_t    wr_idx;
	stream_pkg::slot_t    rd_idx;
	stream_pkg::step_t    step;
	stream_pkg::acc_t     acc;
	stream_pkg::acc_t     mcand;
	stream_pkg::mag_t     mplier;
	logic                 step_end;
	logic                 sample_end;

	function automatic stream_pkg::mag_t magnitude(input stream_pkg::sample_t s);
		if (s[stream_pkg::SAMPLE_W-1]) begin
			return stream_pkg::mag_t'(-s);
		end
		return stream_pkg::mag_t'(s);
	endfunction

	assign ready  = (state == st_idle);
	assign done   = (state == st_hold);
	assign result = acc;

	assign step_end   = (step == stream_pkg::step_t'(stream_pkg::SAMPLE_W - 1));
	assign sample_end = (rd_idx == stream_pkg::slot_t'(stream_pkg::BLOCK_LEN - 1));

	// The dispatcher only addresses this core while it is idle or filling.
	always_ff @(posedge clk) begin
		if (load) begin
			sample_buf[wr_idx] <= sample;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= st_idle;
			wr_idx <= '0;
			rd_idx <= '0;
			step   <= '0;
			acc    <= '0;
			mcand  <= '0;
			mplier <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (load) begin
						wr_idx <= wr_idx + 1'b1;
						state  <= st_fill;
					end
				end
				st_fill: begin
					if (load) begin
						wr_idx <= wr_idx + 1'b1;
						if (last) begin
							// Slot 0 was written on an earlier edge.
							wr_idx <= '0;
							rd_idx <= '0;
							step   <= '0;
							mcand  <= stream_pkg::acc_t'(magnitude(sample_buf[0]));
							mplier <= magnitude(sample_buf[0]);
							state  <= st_square;
						end
					end
				end
				st_square: begin
					// One partial product per cycle, LSB of the multiplier first.
					if (mplier[0]) begin
						acc <= acc + mcand;
					end
					mcand  <= mcand << 1;
					mplier <= mplier >> 1;
					step   <= step + 1'b1;
					if (step_end) begin
						if (sample_end) begin
							state <= st_hold;
						end else begin
							rd_idx <= rd_idx + 1'b1;
							mcand  <= stream_pkg::acc_t'(magnitude(sample_buf[rd_idx + 1'b1]));
							mplier <= magnitude(sample_buf[rd_idx + 1'b1]);
						end
					end
				end
				st_hold: begin
					if (collect) begin
						acc   <= '0;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* rtl/block_dispatcher.sv */
`timescale 1ns/1ps

module block_dispatcher (
	input  logic                                clk,
	input  logic                                arst_n,
	input  stream_pkg::sample_t                 sample_in,
	input  logic [stream_pkg::NUM_CORES-1:0]    core_ready,
	output logic                                sample_take,
	output stream_pkg::sample_t                 core_sample,
	output logic                                core_last,
	output logic [stream_pkg::NUM_CORES-1:0]    core_load
);

	stream_pkg::core_id_t ptr;
	stream_pkg::slot_t    slot;
	logic                 busy;
	logic                 slot_end;

	// A block that has started always runs to its end without a gap.
	assign sample_take = busy || core_ready[ptr];

	assign slot_end = (slot == stream_pkg::slot_t'(stream_pkg::BLOCK_LEN - 1));

	// Samples go to the cores unregistered, so the load edge is the take edge.
	assign core_sample = sample_in;
	assign core_last   = sample_take && slot_end;

	always_comb begin
		core_load = '0;
		if (sample_take) begin
			core_load[ptr] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr  <= '0;
			slot <= '0;
			busy <= 1'b0;
		end else if (sample_take) begin
			if (slot_end) begin
				slot <= '0;
				busy <= 1'b0;
				// Round-robin, so the collector can follow the same order.
				if (ptr == stream_pkg::core_id_t'(stream_pkg::NUM_CORES - 1)) begin
					ptr <= '0;
				end else begin
					ptr <= ptr + 1'b1;
				end
			end else begin
				slot <= slot + 1'b1;
				busy <= 1'b1;
			end
		end
	end

endmodule

/* rtl/stream_pkg.sv */
package stream_pkg;

	// Array sizing.
	localparam int NUM_CORES = 4;
	localparam int BLOCK_LEN = 4;

	// Datapath widths.
	localparam int SAMPLE_W = 16;

	// BLOCK_LEN squares of at most 2**30 each fit in 36 bits with room to spare.
	localparam int ACC_W = 36;

	// Derived index widths.
	localparam int CORE_ID_W = $clog2(NUM_CORES);
	localparam int SLOT_W = $clog2(BLOCK_LEN);
	localparam int STEP_W = $clog2(SAMPLE_W);

	// Signed input sample.
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Unsigned magnitude of a sample; full scale -32768 maps to 32768.
	typedef logic [SAMPLE_W-1:0] mag_t;

	// Block energy, the sum of squares over one block.
	typedef logic [ACC_W-1:0] acc_t;

	// Index of a processing core.
	typedef logic [CORE_ID_W-1:0] core_id_t;

	// Position of a sample within its block.
	typedef logic [SLOT_W-1:0] slot_t;

	// Bit step of the serial squarer.
	typedef logic [STEP_W-1:0] step_t;

endpackage
